/* all.f */
verilog/rename_pkg.sv
verilog/prf.sv
verilog/rename_stage.sv
verilog/alu_unit.sv
verilog/retire_queue.sv
verilog/rename_core_top.sv
verif/tb_clock_gen.sv
verif/tb_rename_core.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Held for 4 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* verif/tb_rename_core.sv */
`timescale 1ns/1ns

module tb_rename_core
    import rename_pkg::*;
();

    logic      clk;
    logic      reset;
    logic      instr_valid;
    t_instr    instr_word;
    logic      instr_ready;
    logic      commit_valid;
    t_gpr_id   commit_gpr;
    t_reg_data commit_data;

    // Architectural state in program order
    t_reg_data model_regs [NUM_GPRS];

    // Expected commits, oldest first
    t_gpr_id   exp_gpr_q [$];
    t_reg_data exp_data_q [$];
    int        exp_cycle_q [$];

    int cycle_cnt;
    int last_accept;

    tb_clock_gen i_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    rename_core_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_word   (instr_word),
        .instr_ready  (instr_ready),
        .commit_valid (commit_valid),
        .commit_gpr   (commit_gpr),
        .commit_data  (commit_data)
    );

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_gpr(input string name, input t_gpr_id actual, input t_gpr_id expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input t_reg_data actual,
                              input t_reg_data expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s = 0x%04h, expected 0x%04h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_cycle(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, actual, expected);
            stop_run();
        end
    endtask

    function automatic t_instr make_rr(input logic [OPCODE_W-1:0] op, input t_gpr_id rd,
                                       input t_gpr_id rs1, input t_gpr_id rs2);
        t_instr w;
        w.r.opcode = op;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        w.r.spare  = '0;
        return w;
    endfunction

    function automatic t_instr make_ri(input t_gpr_id rd, input t_gpr_id rs1,
                                       input logic [IMM_W-1:0] imm);
        t_instr w;
        w.i.opcode = OP_ADDI;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w;
    endfunction

    // Reference result, 16-bit wrapping
    function automatic t_reg_data model_result(input t_instr w);
        t_reg_data a;
        t_reg_data b;
        int        imm_val;
        a       = model_regs[w.r.rs1];
        b       = model_regs[w.r.rs2];
        imm_val = $signed(w.i.imm);
        case (w.r.opcode)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + t_reg_data'(imm_val);
            default: return '0;
        endcase
    endfunction

    // Called just after a rising edge; returns just after the accepting edge
    task automatic send_instr(input t_instr w);
        int        waited;
        t_reg_data result;
        waited      = 0;
        instr_valid = 1'b1;
        instr_word  = w;
        @(negedge clk);
        while (instr_ready !== 1'b1) begin
            waited++;
            if (waited > 50) begin
                $display("Instruction 0x%04h was never accepted, instr_ready stayed low", w);
                stop_run();
            end
            @(negedge clk);
        end
        result      = model_result(w);
        last_accept = cycle_cnt;
        exp_gpr_q.push_back(w.r.rd);
        exp_data_q.push_back(result);
        exp_cycle_q.push_back(cycle_cnt + 2);
        model_regs[w.r.rd] = result;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_gpr_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                $display("Missing commit: %0d accepted instructions never committed",
                         exp_gpr_q.size());
                stop_run();
            end
        end
        // Idle a little so a stray commit shows up
        repeat (4) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_timing();
        repeat (3) begin
            @(negedge clk);
            check_bit("instr_ready", instr_ready, 1'b1);
            check_bit("commit_valid", commit_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        send_instr(make_ri(3'd1, 3'd0, 7'd5));
        wait_drain();
    endtask

    task automatic test_addi_each_reg();
        for (int g = 0; g < NUM_GPRS; g++) begin
            send_instr(make_ri(t_gpr_id'(g), t_gpr_id'($urandom % NUM_GPRS),
                               IMM_W'($urandom)));
        end
        wait_drain();
    endtask

    task automatic test_reg_ops();
        logic [OPCODE_W-1:0] ops [3];
        ops[0] = OP_ADD;
        ops[1] = OP_SUB;
        ops[2] = OP_XOR;
        for (int n = 0; n < 15; n++) begin
            send_instr(make_rr(ops[n % 3], t_gpr_id'($urandom % NUM_GPRS),
                               t_gpr_id'($urandom % NUM_GPRS),
                               t_gpr_id'($urandom % NUM_GPRS)));
        end
        wait_drain();
    endtask

    task automatic test_dep_chain();
        t_gpr_id prev;
        t_gpr_id rd;
        int      prev_accept;
        prev = t_gpr_id'($urandom % NUM_GPRS);
        for (int n = 0; n < 12; n++) begin
            rd = t_gpr_id'($urandom % NUM_GPRS);
            if (n % 2 == 0) begin
                send_instr(make_ri(rd, prev, IMM_W'($urandom)));
            end else begin
                send_instr(make_rr((n % 4 == 1) ? OP_ADD : OP_SUB, rd, prev, prev));
            end
            // Consumer may go in no earlier than its producer's commit
            if (n > 0 && last_accept < prev_accept + 2) begin
                $display("Dependent instruction accepted in cycle %0d, producer in cycle %0d",
                         last_accept, prev_accept);
                stop_run();
            end
            prev_accept = last_accept;
            prev        = rd;
        end
        wait_drain();
    endtask

    task automatic test_free_pressure();
        for (int n = 0; n < 24; n++) begin
            send_instr(make_ri(3'd5, 3'd2, IMM_W'($urandom)));
        end
        wait_drain();
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 2000) begin
            $display("Timeout: run did not finish within 2000 cycles");
            stop_run();
        end
    end

    // Commit monitor
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            if (exp_gpr_q.size() == 0) begin
                $display("Unexpected commit at %0t with no instruction outstanding", $time);
                stop_run();
            end
            check_gpr("commit_gpr", commit_gpr, exp_gpr_q.pop_front());
            check_data("commit_data", commit_data, exp_data_q.pop_front());
            check_cycle("commit cycle", cycle_cnt, exp_cycle_q.pop_front());
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr_word  = '0;
        cycle_cnt   = 0;
        last_accept = 0;
        void'($urandom(61));
        for (int g = 0; g < NUM_GPRS; g++) begin
            model_regs[g] = '0;
        end
        wait (reset === 1'b0);
        @(posedge clk);
        #1;
        test_reset_timing();
        test_addi_each_reg();
        test_reg_ops();
        test_dep_chain();
        test_free_pressure();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit
    import rename_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    // Renamed op, rd0
    input  logic                op_valid,
    input  logic [OPCODE_W-1:0] op_code,
    input  t_prf_id             op_dst_prf,
    input  t_gpr_id             op_dst_gpr,
    input  t_prf_id             op_src_a,
    input  t_prf_id             op_src_b,
    input  t_reg_data           op_imm,

    // File read, address in rd0 and data in rd1
    output t_prf_id             rd_prf_a,
    output t_prf_id             rd_prf_b,
    input  t_reg_data           rd_data_a,
    input  t_reg_data           rd_data_b,

    // Write back in rd1
    output logic                wr_en,
    output t_prf_id             wr_prf,
    output t_reg_data           wr_data,

    output logic                commit_valid,
    output t_gpr_id             commit_gpr,
    output t_reg_data           commit_data
);

    logic                valid_rd1;
    logic [OPCODE_W-1:0] code_rd1;
    t_prf_id             dst_prf_rd1;
    t_gpr_id             dst_gpr_rd1;
    t_reg_data           imm_rd1;
    t_reg_data           result_rd1;

    assign rd_prf_a = op_src_a;
    assign rd_prf_b = op_src_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rd1 <= 1'b0;
        end else begin
            valid_rd1 <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        code_rd1    <= op_code;
        dst_prf_rd1 <= op_dst_prf;
        dst_gpr_rd1 <= op_dst_gpr;
        imm_rd1     <= op_imm;
    end

    // 16-bit wrapping arithmetic
    always_comb begin
        case (code_rd1)
            OP_ADD:  result_rd1 = rd_data_a + rd_data_b;
            OP_SUB:  result_rd1 = rd_data_a - rd_data_b;
            OP_XOR:  result_rd1 = rd_data_a ^ rd_data_b;
            OP_ADDI: result_rd1 = rd_data_a + imm_rd1;
            default: result_rd1 = '0;
        endcase
    end

    assign wr_en   = valid_rd1;
    assign wr_prf  = dst_prf_rd1;
    assign wr_data = result_rd1;

    assign commit_valid = valid_rd1;
    assign commit_gpr   = dst_gpr_rd1;
    assign commit_data  = result_rd1;

endmodule

/* verilog/prf.sv */
`timescale 1ns/1ns

module prf
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Allocation from rename
    input  logic      alloc,
    input  t_gpr_id   alloc_gpr,
    output logic      stall,
    output t_prf_id   alloc_prf,
    output t_prf_id   old_prf,

    // Map reads from rename
    input  t_gpr_id   map_gpr_a,
    input  t_gpr_id   map_gpr_b,
    output t_prf_id   map_prf_a,
    output t_prf_id   map_prf_b,
    output logic      pend_a,
    output logic      pend_b,

    // Data reads, answered one cycle later
    input  t_prf_id   rd_prf_a,
    input  t_prf_id   rd_prf_b,
    output t_reg_data rd_data_a,
    output t_reg_data rd_data_b,

    // Write back from the ALU
    input  logic      wr_en,
    input  t_prf_id   wr_prf,
    input  t_reg_data wr_data,

    // Reclaim from the retire queue
    input  logic      reclaim_en,
    input  t_prf_id   reclaim_prf
);

    t_reg_data                  prf_data [NUM_PRF_ENTRIES];
    t_prf_id                    map_tbl  [NUM_GPRS];
    logic [NUM_PRF_ENTRIES-1:0] free_list;
    logic [NUM_PRF_ENTRIES-1:0] pend_list;

    logic [NUM_PRF_ENTRIES-1:0] alloc_dec;
    logic [NUM_PRF_ENTRIES-1:0] wr_dec;
    logic [NUM_PRF_ENTRIES-1:0] reclaim_dec;
    logic [NUM_PRF_ENTRIES-1:0] pend_cleared;
    logic [NUM_PRF_ENTRIES-1:0] pend_list_nxt;
    logic [NUM_PRF_ENTRIES-1:0] free_list_nxt;

    // Lowest free entry wins
    always_comb begin
        alloc_prf = '0;
        for (int i = NUM_PRF_ENTRIES - 1; i >= 0; i--) begin
            if (free_list[i]) begin
                alloc_prf = t_prf_id'(i);
            end
        end
    end

    assign stall = ~|free_list;

    always_comb begin
        alloc_dec   = '0;
        wr_dec      = '0;
        reclaim_dec = '0;
        if (alloc) begin
            alloc_dec[alloc_prf] = 1'b1;
        end
        if (wr_en) begin
            wr_dec[wr_prf] = 1'b1;
        end
        if (reclaim_en) begin
            reclaim_dec[reclaim_prf] = 1'b1;
        end
    end

    // Writes clear pending in the same cycle so a waiting consumer can go.
    // The new allocation is kept out of the source lookup: no source can map
    // to a free entry, and it keeps instr_ready free of a loop through alloc
    assign pend_cleared  = pend_list & ~wr_dec;
    assign pend_list_nxt = pend_cleared | alloc_dec;
    assign free_list_nxt = (free_list & ~alloc_dec) | reclaim_dec;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_list <= '0;
            for (int i = 0; i < NUM_PRF_ENTRIES; i++) begin
                free_list[i] <= (i >= NUM_GPRS);
            end
        end else begin
            pend_list <= pend_list_nxt;
            free_list <= free_list_nxt;
        end
    end

    // Mapping table, identity out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int g = 0; g < NUM_GPRS; g++) begin
                map_tbl[g] <= t_prf_id'(g);
            end
        end else if (alloc) begin
            map_tbl[alloc_gpr] <= alloc_prf;
        end
    end

    assign old_prf   = map_tbl[alloc_gpr];
    assign map_prf_a = map_tbl[map_gpr_a];
    assign map_prf_b = map_tbl[map_gpr_b];
    assign pend_a    = pend_cleared[map_prf_a];
    assign pend_b    = pend_cleared[map_prf_b];

    // Registers read as zero out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PRF_ENTRIES; i++) begin
                prf_data[i] <= '0;
            end
        end else if (wr_en) begin
            prf_data[wr_prf] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data_a <= prf_data[rd_prf_a];
        rd_data_b <= prf_data[rd_prf_b];
    end

    a_no_alloc_on_stall: assert property (
        @(posedge clk) disable iff (reset) alloc |-> !stall
    ) else $error("allocation while no entry is free");

    a_no_write_to_free: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> !free_list[wr_prf]
    ) else $error("write to free entry %0d", wr_prf);

    a_no_double_reclaim: assert property (
        @(posedge clk) disable iff (reset) reclaim_en |-> !free_list[reclaim_prf]
    ) else $error("reclaim of entry %0d that is already free", reclaim_prf);

endmodule

/* verilog/rename_core_top.sv */
`timescale 1ns/1ns

module rename_core_top
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      instr_valid,
    input  t_instr    instr_word,
    output logic      instr_ready,

    output logic      commit_valid,
    output t_gpr_id   commit_gpr,
    output t_reg_data commit_data
);

    // Rename to file
    t_gpr_id             map_gpr_a;
    t_gpr_id             map_gpr_b;
    t_prf_id             map_prf_a;
    t_prf_id             map_prf_b;
    logic                pend_a;
    logic                pend_b;
    logic                stall;
    logic                alloc;
    t_gpr_id             alloc_gpr;
    t_prf_id             alloc_prf;
    t_prf_id             old_prf;

    // Rename to ALU
    logic                op_valid;
    logic [OPCODE_W-1:0] op_code;
    t_prf_id             op_dst_prf;
    t_gpr_id             op_dst_gpr;
    t_prf_id             op_src_a;
    t_prf_id             op_src_b;
    t_reg_data           op_imm;

    // ALU to file
    t_prf_id             rd_prf_a;
    t_prf_id             rd_prf_b;
    t_reg_data           rd_data_a;
    t_reg_data           rd_data_b;
    logic                wr_en;
    t_prf_id             wr_prf;
    t_reg_data           wr_data;

    // Retire queue to file
    logic                reclaim_en;
    t_prf_id             reclaim_prf;

    rename_stage i_rename (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_ready (instr_ready),
        .map_gpr_a   (map_gpr_a),
        .map_gpr_b   (map_gpr_b),
        .map_prf_a   (map_prf_a),
        .map_prf_b   (map_prf_b),
        .pend_a      (pend_a),
        .pend_b      (pend_b),
        .stall       (stall),
        .alloc_prf   (alloc_prf),
        .alloc       (alloc),
        .alloc_gpr   (alloc_gpr),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .op_dst_prf  (op_dst_prf),
        .op_dst_gpr  (op_dst_gpr),
        .op_src_a    (op_src_a),
        .op_src_b    (op_src_b),
        .op_imm      (op_imm)
    );

    prf i_prf (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .alloc_gpr   (alloc_gpr),
        .stall       (stall),
        .alloc_prf   (alloc_prf),
        .old_prf     (old_prf),
        .map_gpr_a   (map_gpr_a),
        .map_gpr_b   (map_gpr_b),
        .map_prf_a   (map_prf_a),
        .map_prf_b   (map_prf_b),
        .pend_a      (pend_a),
        .pend_b      (pend_b),
        .rd_prf_a    (rd_prf_a),
        .rd_prf_b    (rd_prf_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .wr_en       (wr_en),
        .wr_prf      (wr_prf),
        .wr_data     (wr_data),
        .reclaim_en  (reclaim_en),
        .reclaim_prf (reclaim_prf)
    );

    alu_unit i_alu (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .op_code      (op_code),
        .op_dst_prf   (op_dst_prf),
        .op_dst_gpr   (op_dst_gpr),
        .op_src_a     (op_src_a),
        .op_src_b     (op_src_b),
        .op_imm       (op_imm),
        .rd_prf_a     (rd_prf_a),
        .rd_prf_b     (rd_prf_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .wr_en        (wr_en),
        .wr_prf       (wr_prf),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_gpr   (commit_gpr),
        .commit_data  (commit_data)
    );

    // Old mapping pushed at rename, reclaimed at commit
    retire_queue i_rq (
        .clk         (clk),
        .reset       (reset),
        .push        (alloc),
        .push_prf    (old_prf),
        .pop         (wr_en),
        .reclaim_en  (reclaim_en),
        .reclaim_prf (reclaim_prf)
    );

endmodule

/* verilog/rename_pkg.sv */
package rename_pkg;

    // Architectural and physical sizes
    localparam int NUM_GPRS        = 8;
    localparam int NUM_PRF_ENTRIES = 10;
    localparam int GPR_ID_W        = 3;
    localparam int PRF_ID_W        = 4;
    localparam int DATA_W          = 16;

    // Retire queue
    localparam int RQ_DEPTH = 4;
    localparam int RQ_PTR_W = $clog2(RQ_DEPTH);

    // Instruction fields
    localparam int OPCODE_W = 3;
    localparam int IMM_W    = 7;
    localparam int SPARE_W  = 4;

    localparam logic [OPCODE_W-1:0] OP_ADD  = 3'd0;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 3'd1;
    localparam logic [OPCODE_W-1:0] OP_XOR  = 3'd2;
    localparam logic [OPCODE_W-1:0] OP_ADDI = 3'd3;

    typedef logic [GPR_ID_W-1:0] t_gpr_id;
    typedef logic [PRF_ID_W-1:0] t_prf_id;
    typedef logic [DATA_W-1:0]   t_reg_data;

    // Same 16 bits, two views; the opcode says which one holds
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            t_gpr_id             rd;
            t_gpr_id             rs1;
            t_gpr_id             rs2;
            logic [SPARE_W-1:0]  spare;
        } r;
        struct packed {
            logic [OPCODE_W-1:0]     opcode;
            t_gpr_id                 rd;
            t_gpr_id                 rs1;
            logic signed [IMM_W-1:0] imm;
        } i;
    } t_instr;

endpackage

/* verilog/rename_stage.sv */
`timescale 1ns/1ns

module rename_stage
    import rename_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  logic                instr_valid,
    input  t_instr              instr_word,
    output logic                instr_ready,

    // Register file map and free list
    output t_gpr_id             map_gpr_a,
    output t_gpr_id             map_gpr_b,
    input  t_prf_id             map_prf_a,
    input  t_prf_id             map_prf_b,
    input  logic                pend_a,
    input  logic                pend_b,
    input  logic                stall,
    input  t_prf_id             alloc_prf,
    output logic                alloc,
    output t_gpr_id             alloc_gpr,

    // Renamed op to the ALU
    output logic                op_valid,
    output logic [OPCODE_W-1:0] op_code,
    output t_prf_id             op_dst_prf,
    output t_gpr_id             op_dst_gpr,
    output t_prf_id             op_src_a,
    output t_prf_id             op_src_b,
    output t_reg_data           op_imm
);

    logic      is_imm;
    logic      src_wait;
    t_reg_data imm_ext;

    // Opcode sits at the same bits in both views
    assign is_imm = (instr_word.r.opcode == OP_ADDI);

    assign map_gpr_a = instr_word.r.rs1;
    assign map_gpr_b = instr_word.r.rs2;

    // rs2 bits are part of the immediate in the I form
    assign src_wait = pend_a | (~is_imm & pend_b);

    assign instr_ready = ~stall & ~src_wait;
    assign alloc       = instr_valid & instr_ready;
    assign alloc_gpr   = instr_word.r.rd;

    assign imm_ext = {{(DATA_W - IMM_W){instr_word.i.imm[IMM_W-1]}}, instr_word.i.imm};

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            op_code    <= instr_word.r.opcode;
            op_dst_prf <= alloc_prf;
            op_dst_gpr <= instr_word.r.rd;
            op_src_a   <= map_prf_a;
            op_src_b   <= map_prf_b;
            op_imm     <= imm_ext;
        end
    end

endmodule

/* verilog/retire_queue.sv */
`timescale 1ns/1ns

module retire_queue
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    // Previous mapping of each renamed destination
    input  logic    push,
    input  t_prf_id push_prf,

    // Commit of the oldest op
    input  logic    pop,
    output logic    reclaim_en,
    output t_prf_id reclaim_prf
);

    t_prf_id             rq_mem [RQ_DEPTH];
    logic [RQ_PTR_W-1:0] head;
    logic [RQ_PTR_W-1:0] tail;
    logic [RQ_PTR_W:0]   count;
    logic                full;
    logic                empty;

    assign full  = (count == (RQ_PTR_W + 1)'(RQ_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == RQ_PTR_W'(RQ_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == RQ_PTR_W'(RQ_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // Push and pop together leave the count alone
            count <= count + (RQ_PTR_W + 1)'(push) - (RQ_PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            rq_mem[tail] <= push_prf;
        end
    end

    // Head entry goes back to the free list on commit
    assign reclaim_en  = pop;
    assign reclaim_prf = rq_mem[head];

    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    ) else $error("retire queue push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("retire queue pop while empty");

endmodule
